/* verilog/axil_pkg.sv */
// AXI-Lite widths, response codes, channel payload structs and target register count.
`default_nettype none

package axil_pkg;

    localparam int addr_w = 32;
    localparam int data_w = 32;
    localparam int strb_w = data_w / 8;
    localparam int resp_w = 2;

    // the target decodes this many words starting at address zero.
    localparam int reg_count = 16;
    localparam int idx_w = $clog2(reg_count);

    localparam logic [resp_w-1:0] resp_okay = 2'b00;
    localparam logic [resp_w-1:0] resp_slverr = 2'b10;

    // write address channel payload.
    typedef struct packed {
        logic [addr_w-1:0] addr;
    } axil_aw_t;

    // write data channel payload.
    typedef struct packed {
        logic [data_w-1:0] data;
        logic [strb_w-1:0] strb; // one bit per byte lane.
    } axil_w_t;

    // write response channel payload.
    typedef struct packed {
        logic [resp_w-1:0] resp;
    } axil_b_t;

    // read address channel payload.
    typedef struct packed {
        logic [addr_w-1:0] addr;
    } axil_ar_t;

    // read data channel payload.
    typedef struct packed {
        logic [data_w-1:0] data;
        logic [resp_w-1:0] resp;
    } axil_r_t;

endpackage

`default_nettype wire

/* verilog/axil_if.sv */
// AXI-Lite interface with valid, ready and payload per channel, and its mst and slv modports.
`default_nettype none

interface axil_if import axil_pkg::*; ();

    logic aw_valid;
    logic aw_ready;
    axil_aw_t aw;

    logic w_valid;
    logic w_ready;
    axil_w_t w;

    logic b_valid;
    logic b_ready;
    axil_b_t b;

    logic ar_valid;
    logic ar_ready;
    axil_ar_t ar;

    logic r_valid;
    logic r_ready;
    axil_r_t r;

    // the master issues requests and takes responses.
    modport mst (
        output aw_valid, aw, w_valid, w, ar_valid, ar, b_ready, r_ready,
        input aw_ready, w_ready, ar_ready, b_valid, b, r_valid, r
    );

    // the slave takes requests and returns responses.
    modport slv (
        input aw_valid, aw, w_valid, w, ar_valid, ar, b_ready, r_ready,
        output aw_ready, w_ready, ar_ready, b_valid, b, r_valid, r
    );

endinterface

`default_nettype wire

/* verilog/skid_buffer.sv */
// Two-entry valid/ready skid buffer with a payload type parameter and a bypass option.
`default_nettype none

module skid_buffer #(
    parameter type payload_t = logic [31:0],
    parameter bit bypass = 1'b0
) (
    input logic seq,
    input logic reset,
    input logic in_valid,
    output logic in_ready,
    input payload_t in_data,
    output logic out_valid,
    input logic out_ready,
    output payload_t out_data
);

    if (bypass) begin : g_bypass
        // plain wires, no latency and no path cut.
        assign out_valid = in_valid;
        assign in_ready = out_ready;
        assign out_data = in_data;
    end else begin : g_reg
        logic out_valid_r;
        logic skid_valid_r;
        payload_t out_data_r;
        payload_t skid_data_r;
        logic out_free;

        // the output slot can load when it is empty or being emptied this cycle.
        assign out_free = !out_valid_r || out_ready;

        always_ff @(posedge seq) begin
            if (reset) begin
                out_valid_r <= 1'b0;
                skid_valid_r <= 1'b0;
            end else if (out_free) begin
                if (skid_valid_r) begin
                    out_valid_r <= 1'b1; // the skid entry moves up first.
                    skid_valid_r <= 1'b0;
                end else begin
                    out_valid_r <= in_valid;
                end
            end else if (in_valid && !skid_valid_r) begin
                skid_valid_r <= 1'b1; // output stalled, so park the new item.
            end
        end

        always_ff @(posedge seq) begin
            if (out_free) begin
                out_data_r <= skid_valid_r ? skid_data_r : in_data;
            end
            if (!out_free && !skid_valid_r) begin
                skid_data_r <= in_data;
            end
        end

        // ready is a flop output, so it never sees this cycle's in_valid.
        assign in_ready = !skid_valid_r;
        assign out_valid = out_valid_r;
        assign out_data = out_data_r;

        // a stalled output keeps presenting the same item.
        assert property (@(posedge seq) disable iff (reset)
            out_valid && !out_ready |=> out_valid && $stable(out_data));

        // once a stall fills the skid entry, nothing more is taken next cycle.
        assert property (@(posedge seq) disable iff (reset)
            in_valid && in_ready && out_valid && !out_ready |=> !in_ready);
    end

endmodule

`default_nettype wire

/* verilog/axil_skid.sv */
// AXI-Lite register slice with one skid buffer per channel, each bypassable.
`default_nettype none

module axil_skid import axil_pkg::*; #(
    parameter bit bypass_aw = 1'b0,
    parameter bit bypass_w = 1'b0,
    parameter bit bypass_b = 1'b0,
    parameter bit bypass_ar = 1'b0,
    parameter bit bypass_r = 1'b0
) (
    input logic seq,
    input logic reset,
    axil_if.slv slv,
    axil_if.mst mst
);

    // Request channels run from the slave side to the master side.
    skid_buffer #(
        .payload_t (axil_aw_t),
        .bypass (bypass_aw)
    ) aw_buf (
        .seq (seq),
        .reset (reset),
        .in_valid (slv.aw_valid),
        .in_ready (slv.aw_ready),
        .in_data (slv.aw),
        .out_valid (mst.aw_valid),
        .out_ready (mst.aw_ready),
        .out_data (mst.aw)
    );

    skid_buffer #(
        .payload_t (axil_w_t),
        .bypass (bypass_w)
    ) w_buf (
        .seq (seq),
        .reset (reset),
        .in_valid (slv.w_valid),
        .in_ready (slv.w_ready),
        .in_data (slv.w),
        .out_valid (mst.w_valid),
        .out_ready (mst.w_ready),
        .out_data (mst.w)
    );

    skid_buffer #(
        .payload_t (axil_ar_t),
        .bypass (bypass_ar)
    ) ar_buf (
        .seq (seq),
        .reset (reset),
        .in_valid (slv.ar_valid),
        .in_ready (slv.ar_ready),
        .in_data (slv.ar),
        .out_valid (mst.ar_valid),
        .out_ready (mst.ar_ready),
        .out_data (mst.ar)
    );

    // response channels come back from the master side.
    skid_buffer #(
        .payload_t (axil_b_t),
        .bypass (bypass_b)
    ) b_buf (
        .seq (seq),
        .reset (reset),
        .in_valid (mst.b_valid),
        .in_ready (mst.b_ready),
        .in_data (mst.b),
        .out_valid (slv.b_valid),
        .out_ready (slv.b_ready),
        .out_data (slv.b)
    );

    skid_buffer #(
        .payload_t (axil_r_t),
        .bypass (bypass_r)
    ) r_buf (
        .seq (seq),
        .reset (reset),
        .in_valid (mst.r_valid),
        .in_ready (mst.r_ready),
        .in_data (mst.r),
        .out_valid (slv.r_valid),
        .out_ready (slv.r_ready),
        .out_data (slv.r)
    );

endmodule

`default_nettype wire

/* verilog/axil_reg_target.sv */
// AXI-Lite register target with 16 words, byte strobes and range decoding.
`default_nettype none

module axil_reg_target import axil_pkg::*; (
    input logic seq,
    input logic reset,
    axil_if.slv bus
);

    logic [data_w-1:0] regs [reg_count];

    logic wr_accept;
    logic wr_hit;
    logic [idx_w-1:0] wr_idx;
    logic b_valid_r;
    logic [resp_w-1:0] b_resp_r;

    logic rd_accept;
    logic rd_hit;
    logic [idx_w-1:0] rd_idx;
    logic r_valid_r;
    logic [data_w-1:0] r_data_r;
    logic [resp_w-1:0] r_resp_r;

    // A hit needs a word-aligned address inside the register range.
    function automatic logic in_range(input logic [addr_w-1:0] addr);
        return (addr[1:0] == 2'b00) && (addr[addr_w-1:2] < reg_count);
    endfunction

    // address and data are taken together, only with no response outstanding.
    assign wr_accept = bus.aw_valid && bus.w_valid && !b_valid_r;
    assign wr_hit = in_range(bus.aw.addr);
    assign wr_idx = bus.aw.addr[idx_w+1:2];

    assign bus.aw_ready = wr_accept;
    assign bus.w_ready = wr_accept;

    always_ff @(posedge seq) begin
        if (reset) begin
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_accept && wr_hit) begin
            for (int i = 0; i < strb_w; i++) begin
                if (bus.w.strb[i]) begin
                    regs[wr_idx][i*8 +: 8] <= bus.w.data[i*8 +: 8];
                end
            end
        end
    end

    always_ff @(posedge seq) begin
        if (reset) begin
            b_valid_r <= 1'b0;
        end else if (wr_accept) begin
            b_valid_r <= 1'b1;
        end else if (bus.b_ready) begin
            b_valid_r <= 1'b0; // response taken.
        end
    end

    always_ff @(posedge seq) begin
        if (wr_accept) begin
            b_resp_r <= wr_hit ? resp_okay : resp_slverr;
        end
    end

    assign bus.b_valid = b_valid_r;
    assign bus.b.resp = b_resp_r;

    assign bus.ar_ready = !r_valid_r; // one read in flight at most.
    assign rd_accept = bus.ar_valid && !r_valid_r;
    assign rd_hit = in_range(bus.ar.addr);
    assign rd_idx = bus.ar.addr[idx_w+1:2];

    always_ff @(posedge seq) begin
        if (reset) begin
            r_valid_r <= 1'b0;
        end else if (rd_accept) begin
            r_valid_r <= 1'b1;
        end else if (bus.r_ready) begin
            r_valid_r <= 1'b0;
        end
    end

    // an out-of-range read returns zero data.
    always_ff @(posedge seq) begin
        if (rd_accept) begin
            r_data_r <= rd_hit ? regs[rd_idx] : '0;
            r_resp_r <= rd_hit ? resp_okay : resp_slverr;
        end
    end

    assign bus.r_valid = r_valid_r;
    assign bus.r.data = r_data_r;
    assign bus.r.resp = r_resp_r;

    // a write response only appears right after both write handshakes on the bus.
    assert property (@(posedge seq) disable iff (reset)
        $rose(bus.b_valid) |-> $past(bus.aw_valid && bus.aw_ready
                                     && bus.w_valid && bus.w_ready));

    // read data stays up and unchanged until the master takes it.
    assert property (@(posedge seq) disable iff (reset)
        bus.r_valid && !bus.r_ready |=> bus.r_valid && $stable(bus.r));

endmodule

`default_nettype wire

/* verilog/axil_slice_top.sv */
// Top level with plain AXI-Lite ports, joining the register slice to the register target.
`default_nettype none

module axil_slice_top import axil_pkg::*; (
    input logic seq,
    input logic reset,

    input logic aw_valid,
    output logic aw_ready,
    input logic [addr_w-1:0] aw_addr,

    input logic w_valid,
    output logic w_ready,
    input logic [data_w-1:0] w_data,
    input logic [strb_w-1:0] w_strb,

    output logic b_valid,
    input logic b_ready,
    output logic [resp_w-1:0] b_resp,

    input logic ar_valid,
    output logic ar_ready,
    input logic [addr_w-1:0] ar_addr,

    output logic r_valid,
    input logic r_ready,
    output logic [data_w-1:0] r_data,
    output logic [resp_w-1:0] r_resp
);

    axil_if bus_in ();  // from the ports into the slice.
    axil_if bus_out (); // from the slice into the target.

    assign bus_in.aw_valid = aw_valid;
    assign bus_in.aw.addr = aw_addr;
    assign aw_ready = bus_in.aw_ready;

    assign bus_in.w_valid = w_valid;
    assign bus_in.w.data = w_data;
    assign bus_in.w.strb = w_strb;
    assign w_ready = bus_in.w_ready;

    assign b_valid = bus_in.b_valid;
    assign b_resp = bus_in.b.resp;
    assign bus_in.b_ready = b_ready;

    assign bus_in.ar_valid = ar_valid;
    assign bus_in.ar.addr = ar_addr;
    assign ar_ready = bus_in.ar_ready;

    assign r_valid = bus_in.r_valid;
    assign r_data = bus_in.r.data;
    assign r_resp = bus_in.r.resp;
    assign bus_in.r_ready = r_ready;

    // every channel registered, so all valid and ready paths are cut.
    axil_skid #(
        .bypass_aw (1'b0),
        .bypass_w (1'b0),
        .bypass_b (1'b0),
        .bypass_ar (1'b0),
        .bypass_r (1'b0)
    ) u_skid (
        .seq (seq),
        .reset (reset),
        .slv (bus_in.slv),
        .mst (bus_out.mst)
    );

    axil_reg_target u_target (
        .seq (seq),
        .reset (reset),
        .bus (bus_out.slv)
    );

endmodule

`default_nettype wire

/* tb/tb_clock.sv */
// Clock and reset generator for the testbench.
`default_nettype none

module tb_clock (
    output logic seq,
    output logic reset
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int half_period = 4; // 8 ns clock period.
    localparam int reset_cycles = 5;

    initial begin
        seq = 1'b0;
        forever #half_period seq = ~seq;
    end

    // reset covers five rising edges and drops on a falling edge.
    initial begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge seq);
        @(negedge seq);
        reset = 1'b0;
    end

endmodule

`default_nettype wire

/* tb/tb_axil_slice.sv */
// Testbench for the AXI-Lite slice subsystem, with transactions and expected results from a file.
`default_nettype none

module tb_axil_slice import axil_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int max_items = 128;
    localparam int lead_cycles = 4; // how far one half of a split write runs ahead.
    localparam int name_w = 8 * 24;
    localparam int msg_w = 8 * 72;

    logic seq, reset;
    logic aw_valid, aw_ready;
    logic [addr_w-1:0] aw_addr;
    logic w_valid, w_ready;
    logic [data_w-1:0] w_data;
    logic [strb_w-1:0] w_strb;
    logic b_valid, b_ready;
    logic [resp_w-1:0] b_resp;
    logic ar_valid, ar_ready;
    logic [addr_w-1:0] ar_addr;
    logic r_valid, r_ready;
    logic [data_w-1:0] r_data;
    logic [resp_w-1:0] r_resp;

    logic [63:0] item_op [max_items];
    logic [name_w-1:0] item_name [max_items];
    logic [addr_w-1:0] item_addr [max_items];
    logic [data_w-1:0] item_data [max_items];
    logic [strb_w-1:0] item_strb [max_items];
    logic [resp_w-1:0] item_resp [max_items];
    logic [data_w-1:0] item_rdata [max_items];
    int n_items;
    int b_queue [$]; // items still waiting for their write response, oldest first.
    int r_queue [$];
    logic [15:0] lfsr = 16'd32187;

    tb_clock clk_gen (.seq(seq), .reset(reset));

    axil_slice_top DUT (.*);

    // Fibonacci LFSR with taps 16, 14, 13 and 11.
    function automatic logic [15:0] next_lfsr(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_random_bit(output logic b);
        lfsr = next_lfsr(lfsr);
        b = lfsr[0];
    endtask

    task automatic fail_run(input logic [msg_w-1:0] reason);
        $display("%0s", reason);
        $display("Done: errors found");
        $fatal(1, "stopping at the first failure");
    endtask

    task automatic check_value(input logic [name_w-1:0] test_name, input logic [63:0] field,
                               input logic [data_w-1:0] expected,
                               input logic [data_w-1:0] actual);
        if (expected !== actual) begin
            $display("ERR %0s %0s expected %h actual %h", test_name, field, expected, actual);
            fail_run("a response value did not match");
        end
    endtask

    task automatic load_transactions();
        int fd;
        int code;
        logic [63:0] tok;
        logic [name_w-1:0] name;
        logic [8*128-1:0] rest;
        logic [31:0] f_addr, f_data, f_strb, f_resp, f_rdata;
        fd = $fopen("tb/axil_testdata.txt", "r");
        if (fd == 0) fail_run("the file tb/axil_testdata.txt could not be opened");
        name = "unnamed";
        n_items = 0;
        while ($fscanf(fd, "%s", tok) == 1) begin
            if (tok == "#") begin
                code = $fgets(rest, fd); // skip the rest of a comment line.
            end else if (tok == "T") begin
                code = $fscanf(fd, "%s", name);
            end else begin
                code = $fscanf(fd, "%h %h %h %h %h", f_addr, f_data, f_strb, f_resp, f_rdata);
                if (code != 5 || n_items == max_items
                    || !(tok == "W" || tok == "WA" || tok == "WD" || tok == "R")) begin
                    fail_run("a transaction line in the test data file is malformed");
                end
                item_op[n_items] = tok;
                item_name[n_items] = name;
                item_addr[n_items] = f_addr;
                item_data[n_items] = f_data;
                item_strb[n_items] = f_strb[strb_w-1:0];
                item_resp[n_items] = f_resp[resp_w-1:0];
                item_rdata[n_items] = f_rdata;
                n_items++;
            end
        end
        $fclose(fd);
    endtask

    initial begin
        int cycles, limit, idx, cur, aw_wait, w_wait;
        bit aw_busy, w_busy, ar_busy;
        bit aw_taken, w_taken, ar_taken;
        aw_valid = 1'b0;
        aw_addr = '0;
        w_valid = 1'b0;
        w_data = '0;
        w_strb = '0;
        b_ready = 1'b0;
        ar_valid = 1'b0;
        ar_addr = '0;
        r_ready = 1'b0;
        cycles = 0;
        idx = 0;
        load_transactions();
        limit = 40 * n_items + 100;
        @(negedge reset);
        // the slice leaves reset empty and ready on every request channel.
        check_value("reset_state", "aw_ready", data_w'(1'b1), data_w'(aw_ready));
        check_value("reset_state", "w_ready", data_w'(1'b1), data_w'(w_ready));
        check_value("reset_state", "ar_ready", data_w'(1'b1), data_w'(ar_ready));
        check_value("reset_state", "b_valid", data_w'(1'b0), data_w'(b_valid));
        check_value("reset_state", "r_valid", data_w'(1'b0), data_w'(r_valid));
        while (idx < n_items || aw_busy || w_busy || ar_busy
               || b_queue.size() > 0 || r_queue.size() > 0) begin
            @(negedge seq);
            cycles++;
            if (cycles > limit) fail_run("responses stopped arriving before all were seen");
            aw_busy = aw_busy && !aw_taken; // taken at the last rising edge.
            w_busy = w_busy && !w_taken;
            ar_busy = ar_busy && !ar_taken;
            // the next item starts once the previous request is fully taken.
            if (!aw_busy && !w_busy && !ar_busy && idx < n_items) begin
                if (item_op[idx] == "R") begin
                    if (b_queue.size() == 0) begin // earlier writes must have landed.
                        ar_addr = item_addr[idx];
                        ar_busy = 1'b1;
                        r_queue.push_back(idx);
                        idx++;
                    end
                end else if (r_queue.size() == 0) begin
                    aw_addr = item_addr[idx];
                    w_data = item_data[idx];
                    w_strb = item_strb[idx];
                    aw_wait = (item_op[idx] == "WD") ? lead_cycles : 0;
                    w_wait = (item_op[idx] == "WA") ? lead_cycles : 0;
                    aw_busy = 1'b1;
                    w_busy = 1'b1;
                    b_queue.push_back(idx);
                    idx++;
                end
            end
            aw_valid = aw_busy && (aw_wait == 0);
            w_valid = w_busy && (w_wait == 0);
            ar_valid = ar_busy;
            if (aw_busy && aw_wait > 0) aw_wait--;
            if (w_busy && w_wait > 0) w_wait--;
            // readies and response valids come from flops, so they hold until the next edge.
            aw_taken = aw_valid && aw_ready;
            w_taken = w_valid && w_ready;
            ar_taken = ar_valid && ar_ready;
            take_random_bit(b_ready);
            take_random_bit(r_ready);
            if (b_valid && b_ready) begin
                if (b_queue.size() == 0) fail_run("a write response came with no write pending");
                cur = b_queue.pop_front();
                check_value(item_name[cur], "b_resp", data_w'(item_resp[cur]), data_w'(b_resp));
            end
            if (r_valid && r_ready) begin
                if (r_queue.size() == 0) fail_run("read data came with no read pending");
                cur = r_queue.pop_front();
                check_value(item_name[cur], "r_resp", data_w'(item_resp[cur]), data_w'(r_resp));
                check_value(item_name[cur], "r_data", item_rdata[cur], r_data);
            end
        end
        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire

/* tb/axil_testdata.txt */
# op addr data strb resp rdata in hex; op W, WA (address first), WD (data first), R; T names a group
T reset_state
R 00000000 00000000 0 0 00000000
R 00000004 00000000 0 0 00000000
R 00000008 00000000 0 0 00000000
R 0000000c 00000000 0 0 00000000
R 00000010 00000000 0 0 00000000
R 00000014 00000000 0 0 00000000
R 00000018 00000000 0 0 00000000
R 0000001c 00000000 0 0 00000000
R 00000020 00000000 0 0 00000000
R 00000024 00000000 0 0 00000000
R 00000028 00000000 0 0 00000000
R 0000002c 00000000 0 0 00000000
R 00000030 00000000 0 0 00000000
R 00000034 00000000 0 0 00000000
R 00000038 00000000 0 0 00000000
R 0000003c 00000000 0 0 00000000
T basic_rw
W 00000008 a5a5a5a5 f 0 00000000
R 00000008 00000000 0 0 a5a5a5a5
T byte_strobe
W 00000008 11223344 5 0 00000000
R 00000008 00000000 0 0 a522a544
T split_addr_data
WD 0000000c cafef00d f 0 00000000
WA 00000010 0badbeef f 0 00000000
T back_pressure
W 00000000 00000001 f 0 00000000
W 00000004 12340002 3 0 00000000
W 0000003c fedcba98 c 0 00000000
T range_decode
W 00000040 deadbeef f 2 00000000
W 00000006 deadbeef f 2 00000000
R 00000044 00000000 0 2 00000000
R 00000002 00000000 0 2 00000000
R 00000000 00000000 0 0 00000001
R 00000004 00000000 0 0 00000002
R 00000008 00000000 0 0 a522a544
R 0000000c 00000000 0 0 cafef00d
R 00000010 00000000 0 0 0badbeef
R 00000014 00000000 0 0 00000000
R 00000018 00000000 0 0 00000000
R 0000001c 00000000 0 0 00000000
R 00000020 00000000 0 0 00000000
R 00000024 00000000 0 0 00000000
R 00000028 00000000 0 0 00000000
R 0000002c 00000000 0 0 00000000
R 00000030 00000000 0 0 00000000
R 00000034 00000000 0 0 00000000
R 00000038 00000000 0 0 00000000
R 0000003c 00000000 0 0 fedc0000

/* vlog.f */
verilog/axil_pkg.sv
verilog/axil_if.sv
verilog/skid_buffer.sv
verilog/axil_skid.sv
verilog/axil_reg_target.sv
verilog/axil_slice_top.sv
tb/tb_clock.sv
tb/tb_axil_slice.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it, and look for the fail message in the log.
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_axil_slice -f vlog.f \
    && ./obj_dir/Vtb_axil_slice > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "FAIL: build or simulation failed"; exit 1; }
cat sim.log
grep -q "Done: errors found" sim.log && { echo "FAIL"; exit 1; }
echo "PASS"
exit 0
